// File: filelist.f
logic/dcache_pkg.sv
logic/dcache_ram.sv
logic/dcache_tag_store.sv
logic/dcache_ctrl.sv
logic/dcache_burst_master.sv
logic/dcache_top.sv
testbench/tb_clock.sv
testbench/mem_model.sv
testbench/dcache_tb.sv

// File: logic/dcache_burst_master.sv
`timescale 1ns/1ps

module dcache_burst_master import dcache_pkg::*;
(
   input  logic      clk,
   input  logic      i_reset,
   input  logic      i_rd_start,
   input  logic      i_wr_start,
   input  addr_t     i_line_addr,
   input  logic      i_buf_we,
   input  word_idx_t i_buf_idx,
   input  word_t     i_buf_wdata,
   output word_t     o_buf_rdata,
   output logic      o_done,
   output logic      o_ar_valid,
   input  logic      i_ar_ready,
   output addr_t     o_ar_addr,
   input  logic      i_r_valid,
   output logic      o_r_ready,
   input  word_t     i_r_data,
   input  logic      i_r_last,
   output logic      o_aw_valid,
   input  logic      i_aw_ready,
   output addr_t     o_aw_addr,
   output logic      o_w_valid,
   input  logic      i_w_ready,
   output word_t     o_w_data,
   output logic      o_w_last,
   input  logic      i_b_valid,
   output logic      o_b_ready
);

   word_t     line_buf [LINE_WORDS];
   addr_t     addr_q;
   word_idx_t beat_q;
   logic      ar_valid_q;
   logic      aw_valid_q;
   logic      w_valid_q;
   logic      r_ready_q;
   logic      b_ready_q;
   logic      done_q;
   logic      r_fire;
   logic      w_fire;
   logic      b_fire;

   assign r_fire = i_r_valid & r_ready_q;
   assign w_fire = w_valid_q & i_w_ready;
   assign b_fire = i_b_valid & b_ready_q;

   assign o_ar_valid  = ar_valid_q;
   assign o_ar_addr   = addr_q;
   assign o_r_ready   = r_ready_q;
   assign o_aw_valid  = aw_valid_q;
   assign o_aw_addr   = addr_q;
   assign o_w_valid   = w_valid_q;
   assign o_w_data    = line_buf[beat_q];
   assign o_w_last    = (beat_q == word_idx_t'(LINE_WORDS - 1));
   assign o_b_ready   = b_ready_q;
   assign o_buf_rdata = line_buf[i_buf_idx];
   assign o_done      = done_q;

   // W may run ahead of the AW handshake
   always_ff @(posedge clk)
      begin
         if (i_reset)
            begin
               ar_valid_q <= 1'b0;
               aw_valid_q <= 1'b0;
               w_valid_q  <= 1'b0;
               r_ready_q  <= 1'b0;
               b_ready_q  <= 1'b0;
               done_q     <= 1'b0;
               beat_q     <= '0;
            end
         else
            begin
               ar_valid_q <= i_rd_start | (ar_valid_q & ~i_ar_ready);
               aw_valid_q <= i_wr_start | (aw_valid_q & ~i_aw_ready);
               r_ready_q  <= i_rd_start | (r_ready_q & ~(r_fire & i_r_last));
               w_valid_q  <= i_wr_start | (w_valid_q & ~(w_fire & o_w_last));
               b_ready_q  <= (w_fire & o_w_last) | (b_ready_q & ~i_b_valid);
               done_q     <= (r_fire & i_r_last) | b_fire;
               if (i_rd_start | i_wr_start)
                  beat_q <= '0;
               else if (r_fire | w_fire)
                  beat_q <= beat_q + word_idx_t'(1);
            end
      end

   always_ff @(posedge clk)
      begin
         if (i_rd_start | i_wr_start)
            addr_q <= i_line_addr;
         if (r_fire)
            line_buf[beat_q] <= i_r_data;
         else if (i_buf_we)
            line_buf[i_buf_idx] <= i_buf_wdata;
      end

   assert property (@(posedge clk) disable iff (i_reset)
      o_ar_valid && !i_ar_ready |=> o_ar_valid && $stable(o_ar_addr));
   assert property (@(posedge clk) disable iff (i_reset)
      o_aw_valid && !i_aw_ready |=> o_aw_valid && $stable(o_aw_addr));
   assert property (@(posedge clk) disable iff (i_reset)
      o_w_valid && !i_w_ready |=> o_w_valid && $stable(o_w_data) && $stable(o_w_last));
   // Slave must close the burst exactly on the fourth beat
   assert property (@(posedge clk) disable iff (i_reset)
      r_fire |-> (i_r_last == (beat_q == word_idx_t'(LINE_WORDS - 1))));

endmodule

// File: logic/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*;
(
   input  logic       clk,
   input  logic       i_reset,
   input  logic       i_req_valid,
   output logic       o_req_ready,
   input  addr_t      i_req_addr,
   input  byte_mask_t i_req_wmask,
   input  word_t      i_req_wdata,
   output logic       o_rsp_valid,
   input  logic       i_rsp_ready,
   output word_t      o_rsp_rdata,
   output set_idx_t   o_tag_index,
   output logic       o_tag_re,
   output way_vec_t   o_tag_we,
   output tag_entry_t o_tag_wdata,
   output tag_t       o_lookup_tag,
   output way_vec_t   o_dirty_set,
   output way_vec_t   o_dirty_clr,
   output logic       o_victim_advance,
   input  way_vec_t   i_hit_vec,
   input  way_vec_t   i_victim,
   input  logic       i_victim_dirty,
   input  tag_t       i_victim_tag,
   output data_addr_t o_data_addr,
   output logic       o_data_re,
   output way_vec_t   o_data_we,
   output word_t      o_data_wdata,
   input  word_t      i_data_rdata [NUM_WAYS],
   output logic       o_rd_start,
   output logic       o_wr_start,
   output addr_t      o_line_addr,
   output logic       o_buf_we,
   output word_idx_t  o_buf_idx,
   output word_t      o_buf_wdata,
   input  word_t      i_buf_rdata,
   input  logic       i_done
);

   typedef enum logic [2:0] {
      BOOT, IDLE, LOOKUP, RESPOND, WB_READ, WB_BUS, REFILL_BUS, FILL
   } state_t;

   state_t     state_q;
   state_t     state_nxt;
   set_idx_t   cnt_q;
   addr_t      req_addr_q;
   byte_mask_t req_mask_q;
   word_t      req_wdata_q;
   word_t      data_q;
   way_vec_t   way_q;
   logic       rsp_valid_q;
   logic       req_fire;
   logic       hit;
   logic       cnt_end;
   set_idx_t   req_index;
   word_idx_t  cnt_word;
   word_t      hit_word;
   word_t      merged;

   function automatic word_t pick_way(way_vec_t sel);
      word_t w;
      w = '0;
      for (int i = 0; i < NUM_WAYS; i++)
         if (sel[i])
            w |= i_data_rdata[i];
      return w;
   endfunction

   assign req_fire  = i_req_valid & o_req_ready;
   assign hit       = |i_hit_vec;
   assign req_index = addr_index(req_addr_q);
   assign cnt_word  = cnt_q[WORD_IDX_W-1:0];
   assign cnt_end   = (cnt_q == set_idx_t'(LINE_WORDS));
   assign hit_word  = pick_way(i_hit_vec);

   always_comb
      begin
         merged = hit_word;
         for (int b = 0; b < WORD_BYTES; b++)
            if (req_mask_q[b])
               merged[8*b +: 8] = req_wdata_q[8*b +: 8];
      end

   always_comb
      begin
         state_nxt = state_q;
         case (state_q)
            BOOT:
               if (cnt_q == set_idx_t'(BOOT_CYCLES - 1))
                  state_nxt = IDLE;
            IDLE:
               if (req_fire)
                  state_nxt = LOOKUP;
            LOOKUP:
               if (hit)
                  state_nxt = RESPOND;
               else if (i_victim_dirty)
                  state_nxt = WB_READ;
               else
                  state_nxt = REFILL_BUS;
            RESPOND:
               if (rsp_valid_q & i_rsp_ready)
                  state_nxt = IDLE;
            WB_READ:
               if (cnt_end)
                  state_nxt = WB_BUS;
            WB_BUS:
               if (i_done)
                  state_nxt = REFILL_BUS;
            REFILL_BUS:
               if (i_done)
                  state_nxt = FILL;
            FILL:
               if (cnt_end)
                  state_nxt = LOOKUP;
         endcase
      end

   // Counter restarts on every state change
   always_ff @(posedge clk)
      begin
         if (i_reset)
            begin
               state_q     <= BOOT;
               cnt_q       <= '0;
               rsp_valid_q <= 1'b0;
            end
         else
            begin
               state_q <= state_nxt;
               if (state_nxt != state_q)
                  cnt_q <= '0;
               else
                  cnt_q <= cnt_q + set_idx_t'(1);
               if (state_q == RESPOND)
                  rsp_valid_q <= ~(rsp_valid_q & i_rsp_ready);
            end
      end

   always_ff @(posedge clk)
      begin
         if (req_fire)
            begin
               req_addr_q  <= i_req_addr;
               req_mask_q  <= i_req_wmask;
               req_wdata_q <= i_req_wdata;
            end
         // Read data, or the merged word for a write
         if (state_q == LOOKUP)
            begin
               data_q <= merged;
               way_q  <= i_hit_vec;
            end
      end

   assign o_req_ready = (state_q == IDLE);
   assign o_rsp_valid = rsp_valid_q;
   assign o_rsp_rdata = data_q;

   // Tag store
   assign o_tag_index = (state_q == BOOT) ? cnt_q :
                        (state_q == IDLE) ? addr_index(i_req_addr) : req_index;
   assign o_tag_re    = req_fire | ((state_q == FILL) & cnt_end);
   assign o_tag_we    = (state_q == BOOT) ? '1 :
                        ((state_q == FILL) && (cnt_q == '0)) ? i_victim : '0;
   assign o_tag_wdata = (state_q == BOOT) ? tag_entry_t'('0) :
                        tag_entry_t'{tag: addr_tag(req_addr_q), valid: 1'b1};
   assign o_lookup_tag     = addr_tag(req_addr_q);
   assign o_dirty_set      = ((state_q == LOOKUP) && |req_mask_q) ? i_hit_vec : '0;
   assign o_dirty_clr      = ((state_q == FILL) && (cnt_q == '0)) ? i_victim : '0;
   assign o_victim_advance = (state_q == FILL) & cnt_end;

   // Data RAMs
   always_comb
      begin
         if (state_q == IDLE)
            o_data_addr = {addr_index(i_req_addr), addr_word(i_req_addr)};
         else if (((state_q == WB_READ) || (state_q == FILL)) && !cnt_end)
            o_data_addr = {req_index, cnt_word};
         else
            o_data_addr = {req_index, addr_word(req_addr_q)};
      end

   assign o_data_re = req_fire | ((state_q == WB_READ) & ~cnt_end) |
                      ((state_q == FILL) & cnt_end);
   assign o_data_we = ((state_q == FILL) && !cnt_end) ? i_victim :
                      ((state_q == RESPOND) && !rsp_valid_q && |req_mask_q) ? way_q : '0;
   assign o_data_wdata = (state_q == FILL) ? i_buf_rdata : data_q;

   // Burst master, victim words arrive one cycle after their read
   assign o_wr_start  = (state_q == WB_READ) & cnt_end;
   assign o_rd_start  = ((state_q == LOOKUP) & ~hit & ~i_victim_dirty) |
                        ((state_q == WB_BUS) & i_done);
   assign o_line_addr = (state_q == WB_READ) ? make_line_addr(i_victim_tag, req_index) :
                        make_line_addr(addr_tag(req_addr_q), req_index);
   assign o_buf_we    = (state_q == WB_READ) & (cnt_q != '0);
   assign o_buf_idx   = (state_q == FILL) ? cnt_word : cnt_word - word_idx_t'(1);
   assign o_buf_wdata = pick_way(i_victim);

   assert property (@(posedge clk) disable iff (i_reset) (state_q == BOOT) |-> !o_rsp_valid);

endmodule

// File: logic/dcache_pkg.sv
package dcache_pkg;

   // Cache geometry
   localparam int ADDR_W      = 32;
   localparam int WORD_W      = 32;
   localparam int WORD_BYTES  = WORD_W / 8;
   localparam int LINE_WORDS  = 4;
   localparam int NUM_SETS    = 64;
   localparam int NUM_WAYS    = 2;
   localparam int OFFSET_W    = $clog2(LINE_WORDS * WORD_BYTES);
   localparam int INDEX_W     = $clog2(NUM_SETS);
   localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W;
   localparam int BOOT_CYCLES = NUM_SETS;
   localparam int WORD_IDX_W  = $clog2(LINE_WORDS);
   localparam int BYTE_OFF_W  = $clog2(WORD_BYTES);

   typedef logic [ADDR_W-1:0]             addr_t;
   typedef logic [WORD_W-1:0]             word_t;
   typedef logic [WORD_BYTES-1:0]         byte_mask_t;
   typedef logic [INDEX_W-1:0]            set_idx_t;
   typedef logic [WORD_IDX_W-1:0]         word_idx_t;
   typedef logic [INDEX_W+WORD_IDX_W-1:0] data_addr_t;
   typedef logic [TAG_W-1:0]              tag_t;
   typedef logic [NUM_WAYS-1:0]           way_vec_t;

   typedef struct packed {
      tag_t tag;
      logic valid;
   } tag_entry_t;

   // Address fields
   function automatic set_idx_t addr_index(addr_t addr);
      return addr[OFFSET_W +: INDEX_W];
   endfunction

   function automatic tag_t addr_tag(addr_t addr);
      return addr[ADDR_W-1 -: TAG_W];
   endfunction

   function automatic word_idx_t addr_word(addr_t addr);
      return addr[BYTE_OFF_W +: WORD_IDX_W];
   endfunction

   function automatic addr_t make_line_addr(tag_t tag, set_idx_t index);
      return {tag, index, {OFFSET_W{1'b0}}};
   endfunction

endpackage

// File: logic/dcache_ram.sv
`timescale 1ns/1ps

module dcache_ram import dcache_pkg::*;
#(
   parameter type T_DATA     = word_t,
   parameter int  DEPTH_LOG2 = 8
)
(
   input  logic                  clk,
   input  logic [DEPTH_LOG2-1:0] i_addr,
   input  logic                  i_re,
   input  logic                  i_we,
   input  T_DATA                 i_wdata,
   output T_DATA                 o_rdata
);

   T_DATA mem [1<<DEPTH_LOG2];

   // Read returns the old entry on a same-cycle write
   always_ff @(posedge clk)
      begin
         if (i_we)
            mem[i_addr] <= i_wdata;
         if (i_re)
            o_rdata <= mem[i_addr];
      end

endmodule

// File: logic/dcache_tag_store.sv
`timescale 1ns/1ps

module dcache_tag_store import dcache_pkg::*;
(
   input  logic       clk,
   input  logic       i_reset,
   input  set_idx_t   i_index,
   input  logic       i_re,
   input  way_vec_t   i_tag_we,
   input  tag_entry_t i_tag_wdata,
   input  tag_t       i_lookup_tag,
   input  way_vec_t   i_dirty_set,
   input  way_vec_t   i_dirty_clr,
   input  logic       i_victim_advance,
   output way_vec_t   o_hit_vec,
   output way_vec_t   o_victim,
   output logic       o_victim_dirty,
   output tag_t       o_victim_tag
);

   tag_entry_t tag_rdata [NUM_WAYS];
   way_vec_t   dirty_q [NUM_SETS];
   set_idx_t   index_q;
   way_vec_t   victim_q;

   for (genvar w = 0; w < NUM_WAYS; w++)
      begin : gen_way
         dcache_ram
            #(
               .T_DATA     (tag_entry_t),
               .DEPTH_LOG2 (INDEX_W)
            )
         u_tag_ram
            (
               .clk     (clk),
               .i_addr  (i_index),
               .i_re    (i_re),
               .i_we    (i_tag_we[w]),
               .i_wdata (i_tag_wdata),
               .o_rdata (tag_rdata[w])
            );

         assign o_hit_vec[w] = tag_rdata[w].valid & (tag_rdata[w].tag == i_lookup_tag);
      end

   always_comb
      begin
         o_victim_tag = '0;
         for (int w = 0; w < NUM_WAYS; w++)
            if (victim_q[w])
               o_victim_tag |= tag_rdata[w].tag;
      end

   assign o_victim       = victim_q;
   assign o_victim_dirty = |(dirty_q[index_q] & victim_q);

   // Set of the last lookup, used for the dirty flags
   always_ff @(posedge clk)
      if (i_re)
         index_q <= i_index;

   always_ff @(posedge clk)
      begin
         if (i_reset)
            begin
               victim_q <= way_vec_t'(1);
               for (int s = 0; s < NUM_SETS; s++)
                  dirty_q[s] <= '0;
            end
         else
            begin
               // Round-robin, one step per refill
               if (i_victim_advance)
                  victim_q <= {victim_q[NUM_WAYS-2:0], victim_q[NUM_WAYS-1]};
               if (|(i_dirty_set | i_dirty_clr))
                  dirty_q[index_q] <= (dirty_q[index_q] | i_dirty_set) & ~i_dirty_clr;
            end
      end

   assert property (@(posedge clk) disable iff (i_reset) i_re |=> $onehot0(o_hit_vec));

endmodule

// File: logic/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*;
(
   input  logic       clk,
   input  logic       i_reset,
   // Load/store unit
   input  logic       i_req_valid,
   output logic       o_req_ready,
   input  addr_t      i_req_addr,
   input  byte_mask_t i_req_wmask,
   input  word_t      i_req_wdata,
   output logic       o_rsp_valid,
   input  logic       i_rsp_ready,
   output word_t      o_rsp_rdata,
   // Memory bus
   output logic       o_ar_valid,
   input  logic       i_ar_ready,
   output addr_t      o_ar_addr,
   input  logic       i_r_valid,
   output logic       o_r_ready,
   input  word_t      i_r_data,
   input  logic       i_r_last,
   output logic       o_aw_valid,
   input  logic       i_aw_ready,
   output addr_t      o_aw_addr,
   output logic       o_w_valid,
   input  logic       i_w_ready,
   output word_t      o_w_data,
   output logic       o_w_last,
   input  logic       i_b_valid,
   output logic       o_b_ready
);

   set_idx_t   tag_index;
   logic       tag_re;
   way_vec_t   tag_we;
   tag_entry_t tag_wdata;
   tag_t       lookup_tag;
   way_vec_t   dirty_set;
   way_vec_t   dirty_clr;
   logic       victim_advance;
   way_vec_t   hit_vec;
   way_vec_t   victim;
   logic       victim_dirty;
   tag_t       victim_tag;
   data_addr_t data_addr;
   logic       data_re;
   way_vec_t   data_we;
   word_t      data_wdata;
   word_t      data_rdata [NUM_WAYS];
   logic       rd_start;
   logic       wr_start;
   addr_t      bus_line_addr;
   logic       buf_we;
   word_idx_t  buf_idx;
   word_t      buf_wdata;
   word_t      buf_rdata;
   logic       burst_done;

   dcache_ctrl u_ctrl
      (
         .o_tag_index      (tag_index),
         .o_tag_re         (tag_re),
         .o_tag_we         (tag_we),
         .o_tag_wdata      (tag_wdata),
         .o_lookup_tag     (lookup_tag),
         .o_dirty_set      (dirty_set),
         .o_dirty_clr      (dirty_clr),
         .o_victim_advance (victim_advance),
         .i_hit_vec        (hit_vec),
         .i_victim         (victim),
         .i_victim_dirty   (victim_dirty),
         .i_victim_tag     (victim_tag),
         .o_data_addr      (data_addr),
         .o_data_re        (data_re),
         .o_data_we        (data_we),
         .o_data_wdata     (data_wdata),
         .i_data_rdata     (data_rdata),
         .o_rd_start       (rd_start),
         .o_wr_start       (wr_start),
         .o_line_addr      (bus_line_addr),
         .o_buf_we         (buf_we),
         .o_buf_idx        (buf_idx),
         .o_buf_wdata      (buf_wdata),
         .i_buf_rdata      (buf_rdata),
         .i_done           (burst_done),
         .*
      );

   dcache_tag_store u_tag_store
      (
         .clk              (clk),
         .i_reset          (i_reset),
         .i_index          (tag_index),
         .i_re             (tag_re),
         .i_tag_we         (tag_we),
         .i_tag_wdata      (tag_wdata),
         .i_lookup_tag     (lookup_tag),
         .i_dirty_set      (dirty_set),
         .i_dirty_clr      (dirty_clr),
         .i_victim_advance (victim_advance),
         .o_hit_vec        (hit_vec),
         .o_victim         (victim),
         .o_victim_dirty   (victim_dirty),
         .o_victim_tag     (victim_tag)
      );

   // One data RAM per way, addressed by set and word
   for (genvar w = 0; w < NUM_WAYS; w++)
      begin : gen_data_way
         dcache_ram
            #(
               .T_DATA     (word_t),
               .DEPTH_LOG2 ($bits(data_addr_t))
            )
         u_data_ram
            (
               .clk     (clk),
               .i_addr  (data_addr),
               .i_re    (data_re),
               .i_we    (data_we[w]),
               .i_wdata (data_wdata),
               .o_rdata (data_rdata[w])
            );
      end

   dcache_burst_master u_burst_master
      (
         .i_rd_start  (rd_start),
         .i_wr_start  (wr_start),
         .i_line_addr (bus_line_addr),
         .i_buf_we    (buf_we),
         .i_buf_idx   (buf_idx),
         .i_buf_wdata (buf_wdata),
         .o_buf_rdata (buf_rdata),
         .o_done      (burst_done),
         .*
      );

endmodule

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dcache_tb \
   -f filelist.f --Mdir obj_dir -o dcache_sim
if [ $? -ne 0 ]; then
   echo "Build error"
   exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulator returned status $status"
   exit 1
fi

if echo "$out" | grep -q "Simulation completed successfully"; then
   exit 0
fi
exit 1

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb import dcache_pkg::*;
();

   localparam int N_ENTRIES   = 39;
   localparam int N_RANDOM    = 30;
   localparam int MEM_WORDS   = 4096;
   localparam int WATCHDOG_NS = (N_ENTRIES * 80 + BOOT_CYCLES + 16) * 20;

   logic       clk;
   logic       i_reset;
   logic       i_req_valid;
   logic       o_req_ready;
   addr_t      i_req_addr;
   byte_mask_t i_req_wmask;
   word_t      i_req_wdata;
   logic       o_rsp_valid;
   logic       i_rsp_ready;
   word_t      o_rsp_rdata;
   logic       ar_valid, ar_ready, r_valid, r_ready, r_last;
   logic       aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
   addr_t      ar_addr, aw_addr;
   word_t      r_data, w_data;

   // Table columns: op (1 write), address, mask, data, bus check
   // Bus check 0 none, 1 no AR burst, 2 one AW burst
   logic       op_tab [N_ENTRIES];
   addr_t      addr_tab [N_ENTRIES];
   byte_mask_t mask_tab [N_ENTRIES];
   word_t      data_tab [N_ENTRIES];
   int         chk_tab [N_ENTRIES];
   int         n_fill = 0;
   word_t      shadow [MEM_WORDS];
   integer     seed = 53;
   int         errors = 0;
   int         tests_run = 0;
   int         tests_failed = 0;

   tb_clock #(.PERIOD_NS(20)) u_clock (.o_clk(clk));

   dcache_top UUT
      (
         .clk         (clk),
         .i_reset     (i_reset),
         .i_req_valid (i_req_valid),
         .o_req_ready (o_req_ready),
         .i_req_addr  (i_req_addr),
         .i_req_wmask (i_req_wmask),
         .i_req_wdata (i_req_wdata),
         .o_rsp_valid (o_rsp_valid),
         .i_rsp_ready (i_rsp_ready),
         .o_rsp_rdata (o_rsp_rdata),
         .o_ar_valid  (ar_valid),
         .i_ar_ready  (ar_ready),
         .o_ar_addr   (ar_addr),
         .i_r_valid   (r_valid),
         .o_r_ready   (r_ready),
         .i_r_data    (r_data),
         .i_r_last    (r_last),
         .o_aw_valid  (aw_valid),
         .i_aw_ready  (aw_ready),
         .o_aw_addr   (aw_addr),
         .o_w_valid   (w_valid),
         .i_w_ready   (w_ready),
         .o_w_data    (w_data),
         .o_w_last    (w_last),
         .i_b_valid   (b_valid),
         .o_b_ready   (b_ready)
      );

   mem_model u_mem
      (
         .clk        (clk),
         .i_ar_valid (ar_valid),
         .o_ar_ready (ar_ready),
         .i_ar_addr  (ar_addr),
         .o_r_valid  (r_valid),
         .i_r_ready  (r_ready),
         .o_r_data   (r_data),
         .o_r_last   (r_last),
         .i_aw_valid (aw_valid),
         .o_aw_ready (aw_ready),
         .i_aw_addr  (aw_addr),
         .i_w_valid  (w_valid),
         .o_w_ready  (w_ready),
         .i_w_data   (w_data),
         .i_w_last   (w_last),
         .o_b_valid  (b_valid),
         .i_b_ready  (b_ready)
      );

   function automatic int word_index(addr_t a);
      return int'(a[13:2]);
   endfunction

   function automatic word_t merge_bytes(word_t old, word_t wdata, byte_mask_t mask);
      word_t res;
      res = old;
      for (int b = 0; b < WORD_BYTES; b++)
         if (mask[b])
            res[8*b +: 8] = wdata[8*b +: 8];
      return res;
   endfunction

   task automatic add_entry(logic op, addr_t a, byte_mask_t m, word_t d, int chk);
      op_tab[n_fill]   = op;
      addr_tab[n_fill] = a;
      mask_tab[n_fill] = m;
      data_tab[n_fill] = d;
      chk_tab[n_fill]  = chk;
      n_fill++;
   endtask

   task automatic build_table();
      int r;
      add_entry(1'b0, 32'h0000_0000, 4'h0, '0, 0);
      add_entry(1'b0, 32'h0000_03f4, 4'h0, '0, 0);
      add_entry(1'b1, 32'h0000_0104, 4'b0011, 32'hcafe_1234, 0);
      add_entry(1'b0, 32'h0000_0104, 4'h0, '0, 0);
      add_entry(1'b0, 32'h0000_0108, 4'h0, '0, 1);
      // Set 5, three tags; the third evicts the dirty first
      add_entry(1'b1, 32'h0000_0050, 4'hf, 32'h1357_9bdf, 0);
      add_entry(1'b0, 32'h0000_0450, 4'h0, '0, 0);
      add_entry(1'b0, 32'h0000_0850, 4'h0, '0, 2);
      add_entry(1'b0, 32'h0000_0050, 4'h0, '0, 0);
      for (int i = 0; i < N_RANDOM; i++)
         begin
            r = $random(seed);
            add_entry(r[16], {18'd0, r[13:10], 4'd0, r[5:4], r[3:2], 2'b00},
                      r[16] ? ((r[20:17] == 4'h0) ? 4'hf : r[20:17]) : 4'h0,
                      $random(seed), 0);
         end
   endtask

   task automatic run_entry(int k);
      word_t got;
      word_t exp;
      int    ar0;
      int    aw0;
      int    r;
      logic  fired;
      logic  ok;
      ok  = 1'b1;
      ar0 = u_mem.ar_count;
      aw0 = u_mem.aw_count;
      i_req_valid = 1'b1;
      i_req_addr  = addr_tab[k];
      i_req_wmask = mask_tab[k];
      i_req_wdata = data_tab[k];
      fired = 1'b0;
      // Ready seen here holds through the next rising edge
      while (!fired)
         begin
            fired = o_req_ready;
            @(negedge clk);
         end
      i_req_valid = 1'b0;
      fired = 1'b0;
      got   = '0;
      // Random response back-pressure
      while (!fired)
         begin
            r = $random(seed);
            i_rsp_ready = r[0] | r[1];
            fired = o_rsp_valid & i_rsp_ready;
            got   = o_rsp_rdata;
            @(negedge clk);
         end
      i_rsp_ready = 1'b0;
      exp = shadow[word_index(addr_tab[k])];
      if (op_tab[k])
         shadow[word_index(addr_tab[k])] = merge_bytes(exp, data_tab[k], mask_tab[k]);
      else
         assert (got === exp)
         else
            begin
               $display("Fail test %0d o_rsp_rdata got %h expected %h", k, got, exp);
               ok = 1'b0;
            end
      if (chk_tab[k] == 1)
         assert (u_mem.ar_count == ar0)
         else
            begin
               $display("Test %0d: a read of a cached line started a bus read burst", k);
               ok = 1'b0;
            end
      if (chk_tab[k] == 2)
         assert (u_mem.aw_count == aw0 + 1)
         else
            begin
               $display("Test %0d: the dirty victim line was not written back", k);
               ok = 1'b0;
            end
      tests_run++;
      if (!ok)
         begin
            errors++;
            tests_failed++;
         end
      $display("Test %0d %s addr %h %s", k, op_tab[k] ? "write" : "read", addr_tab[k],
               ok ? "ok" : "error");
   endtask

   initial
      begin
         #WATCHDOG_NS;
         $display("Watchdog expired before all tests finished");
         $display("Simulation failed");
         $finish;
      end

   initial
      begin
         int cycles;
         logic ok;
         i_reset     = 1'b1;
         i_req_valid = 1'b0;
         i_req_addr  = '0;
         i_req_wmask = '0;
         i_req_wdata = '0;
         i_rsp_ready = 1'b0;
         build_table();
         ok = 1'b1;
         for (int i = 0; i < 16; i++)
            begin
               @(negedge clk);
               assert (!o_req_ready)
               else
                  begin
                     $display("Fail o_req_ready during reset got %h expected %h", o_req_ready, 1'b0);
                     ok = 1'b0;
                  end
            end
         i_reset = 1'b0;
         for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = u_mem.mem[i];
         // Ready comes up after the boot sweep of all sets
         cycles = 0;
         while (!o_req_ready && cycles <= BOOT_CYCLES + 4)
            begin
               @(negedge clk);
               cycles++;
            end
         assert (cycles == BOOT_CYCLES)
         else
            begin
               $display("Fail boot cycles got %h expected %h", cycles, BOOT_CYCLES);
               ok = 1'b0;
            end
         tests_run++;
         if (!ok)
            begin
               errors++;
               tests_failed++;
            end
         $display("Test boot %s", ok ? "ok" : "error");
         for (int k = 0; k < N_ENTRIES; k++)
            run_entry(k);
         assert (u_mem.bus_errors == 0)
         else
            begin
               $display("Memory model saw %0d bus protocol errors", u_mem.bus_errors);
               errors++;
            end
         $display("Tests run %0d, passed %0d, failed %0d", tests_run,
                  tests_run - tests_failed, tests_failed);
         if (errors == 0)
            $display("Simulation completed successfully");
         else
            $display("Simulation failed");
         $finish;
      end

endmodule

// File: testbench/mem_model.sv
`timescale 1ns/1ps

module mem_model import dcache_pkg::*;
(
   input  logic  clk,
   input  logic  i_ar_valid,
   output logic  o_ar_ready,
   input  addr_t i_ar_addr,
   output logic  o_r_valid,
   input  logic  i_r_ready,
   output word_t o_r_data,
   output logic  o_r_last,
   input  logic  i_aw_valid,
   output logic  o_aw_ready,
   input  addr_t i_aw_addr,
   input  logic  i_w_valid,
   output logic  o_w_ready,
   input  word_t i_w_data,
   input  logic  i_w_last,
   output logic  o_b_valid,
   input  logic  i_b_ready
);

   localparam int MEM_WORDS = 4096;

   word_t  mem [MEM_WORDS];
   word_t  wbuf [LINE_WORDS];
   integer seed = 53;
   int     ar_count = 0;
   int     aw_count = 0;
   int     bus_errors = 0;
   logic   ar_fire, r_fire, aw_fire, w_fire, b_fire;
   addr_t  ar_addr_s, aw_addr_s;
   word_t  w_data_s;
   logic   w_last_s;
   logic   rd_active = 1'b0;
   addr_t  rd_addr;
   int     rd_beat = 0;
   logic   aw_got = 1'b0;
   addr_t  wr_addr;
   int     wr_beats = 0;

   function automatic int word_index(addr_t a);
      return int'(a[13:2]);
   endfunction

   initial
      begin
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = $random(seed);
         o_ar_ready = 1'b0;
         o_r_valid  = 1'b0;
         o_r_data   = '0;
         o_r_last   = 1'b0;
         o_aw_ready = 1'b0;
         o_w_ready  = 1'b0;
         o_b_valid  = 1'b0;
      end

   // Handshakes seen at the rising edge
   always @(posedge clk)
      begin
         ar_fire   = i_ar_valid & o_ar_ready;
         r_fire    = o_r_valid & i_r_ready;
         aw_fire   = i_aw_valid & o_aw_ready;
         w_fire    = i_w_valid & o_w_ready;
         b_fire    = o_b_valid & i_b_ready;
         ar_addr_s = i_ar_addr;
         aw_addr_s = i_aw_addr;
         w_data_s  = i_w_data;
         w_last_s  = i_w_last;
      end

   always @(negedge clk)
      begin
         int r;
         if (ar_fire)
            begin
               if (ar_addr_s[OFFSET_W-1:0] != '0)
                  begin
                     $display("Bus error: read burst address %h is not line aligned", ar_addr_s);
                     bus_errors++;
                  end
               rd_active = 1'b1;
               rd_addr   = ar_addr_s;
               rd_beat   = 0;
               ar_count++;
            end
         if (r_fire)
            begin
               rd_beat++;
               if (rd_beat == LINE_WORDS)
                  rd_active = 1'b0;
            end
         if (aw_fire)
            begin
               if (aw_addr_s[OFFSET_W-1:0] != '0)
                  begin
                     $display("Bus error: write burst address %h is not line aligned", aw_addr_s);
                     bus_errors++;
                  end
               aw_got  = 1'b1;
               wr_addr = aw_addr_s;
               aw_count++;
            end
         if (w_fire)
            begin
               if (w_last_s != (wr_beats == LINE_WORDS - 1))
                  begin
                     $display("Bus error: write last flag wrong on beat %0d", wr_beats);
                     bus_errors++;
                  end
               wbuf[wr_beats] = w_data_s;
               wr_beats++;
            end
         if (b_fire)
            o_b_valid = 1'b0;
         // Commit the line once both address and all beats are in
         if (aw_got && (wr_beats == LINE_WORDS) && !o_b_valid)
            begin
               for (int i = 0; i < LINE_WORDS; i++)
                  mem[word_index(wr_addr) + i] = wbuf[i];
               o_b_valid = 1'b1;
               aw_got    = 1'b0;
               wr_beats  = 0;
            end
         r = $random(seed);
         o_ar_ready = r[0];
         o_aw_ready = r[1];
         o_w_ready  = r[2];
         if (!rd_active)
            o_r_valid = 1'b0;
         else if (!(o_r_valid && !r_fire))
            begin
               o_r_valid = r[3];
               o_r_data  = mem[word_index(rd_addr) + rd_beat];
               o_r_last  = (rd_beat == LINE_WORDS - 1);
            end
      end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
   parameter int PERIOD_NS = 20
)
(
   output logic o_clk
);

   initial
      begin
         o_clk = 1'b0;
         forever
            #(PERIOD_NS / 2) o_clk = ~o_clk;
      end

endmodule
